/* nic_bypass.f */
+incdir+tests
rtl/nic_bypass_pkg.sv
rtl/stream_fifo.sv
rtl/output_port_lookup.sv
rtl/axis_register_slice.sv
rtl/nic_bypass_top.sv
tests/nic_bypass_tb.sv

/* Makefile */
# Verilator simulation of the bypass stage
LOG := sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module nic_bypass_tb -f nic_bypass.f -Mdir obj_dir -o nic_bypass_sim
	./obj_dir/nic_bypass_sim 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tests/nic_bypass_model.svh */
/*
 * Reference model of the bypass stage, expected-beat queue
 * Port mapping, first-beat rewrite and the value check
 */
`ifndef NIC_BYPASS_MODEL_SVH
`define NIC_BYPASS_MODEL_SVH

// Beats accepted at s_axis, in order, already rewritten
axis_beat_t  expected_q[$];
logic        model_first = 1'b1;
int unsigned mac_packets = 0;
int unsigned cpu_packets = 0;

// Even bit is a MAC port, its CPU queue sits one bit above
function automatic port_map_t map_port(input port_map_t src);
   port_map_t dst;
   dst = '0;
   for (int i = 0; i < PORT_MAP_WIDTH; i++) begin
      if (src[i]) begin
         if (i % 2 == 0) begin
            dst[i+1] = 1'b1;
         end else begin
            dst[i-1] = 1'b1;
         end
      end
   end
   return dst;
endfunction

// Compare one field and stop on a mismatch
task automatic check_value(input string name, input logic [CMP_WIDTH-1:0] got,
                           input logic [CMP_WIDTH-1:0] expected);
   if (got !== expected) begin
      fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, expected));
   end
endtask

// Model of one accepted input beat
task automatic push_expected(input axis_beat_t beat);
   axis_beat_t rewritten;
   rewritten = beat;
   if (model_first) begin
      rewritten.user[DST_PORT_POS +: PORT_MAP_WIDTH] =
         map_port(beat.user[SRC_PORT_POS +: PORT_MAP_WIDTH]);
      // Direction tally for the end of run
      if (|(beat.user[SRC_PORT_POS +: PORT_MAP_WIDTH] & 8'h55)) begin
         mac_packets++;
      end else begin
         cpu_packets++;
      end
   end
   expected_q.push_back(rewritten);
   model_first = beat.last;
endtask

// Beat taken at m_axis against the head of the queue
task automatic compare_output();
   axis_beat_t expected;
   if (expected_q.size() == 0) begin
      fail_run("A beat left the DUT while no beat was outstanding");
   end else begin
      expected = expected_q.pop_front();
      check_value("m_axis_tlast", CMP_WIDTH'(m_axis_tlast), CMP_WIDTH'(expected.last));
      check_value("m_axis_tuser", CMP_WIDTH'(m_axis_tuser), CMP_WIDTH'(expected.user));
      check_value("m_axis_tstrb", CMP_WIDTH'(m_axis_tstrb), CMP_WIDTH'(expected.strb));
      check_value("m_axis_tdata", m_axis_tdata, expected.data);
   end
endtask

`endif

/* tests/nic_bypass_tb.sv */
/*
 * Testbench for the bypass stage, random packets with back-pressure
 * Clock, reset, driver, monitors, timeout and end-of-run result
 */
`timescale 1ns/1ns
`default_nettype none

module nic_bypass_tb;

   import nic_bypass_pkg::*;

   localparam int SRC_PORT_POS    = 16;
   localparam int DST_PORT_POS    = 24;
   localparam int FIFO_DEPTH_BITS = 2;
   localparam int CMP_WIDTH       = AXIS_DATA_WIDTH;
   localparam int NUM_PACKETS     = 200;
   localparam int MAX_BEATS       = 6;
   // Worst case 8 cycles per beat, plus margin for the drain
   localparam int TIMEOUT_CYCLES  = NUM_PACKETS * MAX_BEATS * 8 + 2000;

   logic        axi_aclk;
   logic        axi_resetn;
   axis_data_t  s_axis_tdata;
   axis_strb_t  s_axis_tstrb;
   axis_user_t  s_axis_tuser;
   logic        s_axis_tvalid;
   logic        s_axis_tlast;
   logic        s_axis_tready;
   axis_data_t  m_axis_tdata;
   axis_strb_t  m_axis_tstrb;
   axis_user_t  m_axis_tuser;
   logic        m_axis_tvalid;
   logic        m_axis_tlast;
   logic        m_axis_tready;
   int unsigned cycle_count;
   logic        saw_stall;
   logic        saw_recover;

   // Stop the run with a reason
   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   `include "nic_bypass_model.svh"

   nic_bypass_top #(
      .SRC_PORT_POS    (SRC_PORT_POS),
      .DST_PORT_POS    (DST_PORT_POS),
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) nic_bypass_top_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tready (m_axis_tready)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #5 axi_aclk = ~axi_aclk;
   end

   //////////////////////////////
   // Random beats
   //////////////////////////////

   function automatic axis_data_t random_data();
      axis_data_t data;
      for (int i = 0; i < AXIS_DATA_WIDTH / 32; i++) begin
         data[i*32 +: 32] = $urandom;
      end
      return data;
   endfunction

   // Random tuser around a fixed source byte
   function automatic axis_user_t random_user(input port_map_t src);
      axis_user_t user;
      for (int i = 0; i < AXIS_USER_WIDTH / 32; i++) begin
         user[i*32 +: 32] = $urandom;
      end
      user[SRC_PORT_POS +: PORT_MAP_WIDTH] = src;
      return user;
   endfunction

   // Offer one beat after a random gap, hold until taken
   task automatic send_beat(input axis_beat_t beat);
      logic accepted;
      while ($urandom_range(3) == 0) begin
         s_axis_tvalid = 1'b0;
         @(posedge axi_aclk);
         #1;
      end
      s_axis_tdata  = beat.data;
      s_axis_tstrb  = beat.strb;
      s_axis_tuser  = beat.user;
      s_axis_tlast  = beat.last;
      s_axis_tvalid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
         // Ready only moves on the rising edge
         @(negedge axi_aclk);
         accepted = s_axis_tready;
         @(posedge axi_aclk);
         #1;
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_packet();
      int unsigned num_beats;
      port_map_t   src;
      axis_beat_t  beat;
      num_beats = $urandom_range(MAX_BEATS, 1);
      src = port_map_t'(1) << $urandom_range(PORT_MAP_WIDTH - 1);
      for (int unsigned b = 0; b < num_beats; b++) begin
         beat.data = random_data();
         beat.strb = $urandom;
         beat.user = random_user(src);
         beat.last = (b == num_beats - 1);
         send_beat(beat);
      end
   endtask

   //////////////////////////////
   // Monitors
   //////////////////////////////

   // Sample mid-cycle where both sides are settled
   always @(negedge axi_aclk) begin
      if (!axi_resetn) begin
         // Synchronous reset takes hold at the first edge
         if (cycle_count != 0) begin
            check_value("m_axis_tvalid", CMP_WIDTH'(m_axis_tvalid), CMP_WIDTH'(1'b0));
            check_value("s_axis_tready", CMP_WIDTH'(s_axis_tready), CMP_WIDTH'(1'b1));
         end
      end else begin
         if (s_axis_tvalid && s_axis_tready) begin
            push_expected({s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata});
         end
         if (m_axis_tvalid && m_axis_tready) begin
            compare_output();
         end
         // Upstream back-pressure seen and released
         if (!s_axis_tready) begin
            saw_stall <= 1'b1;
         end else if (saw_stall) begin
            saw_recover <= 1'b1;
         end
      end
   end

   always @(posedge axi_aclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         fail_run("Timeout: the run did not finish within the cycle limit");
      end
   end

   // Downstream stalls about half the time
   always @(posedge axi_aclk) begin
      #1;
      m_axis_tready = ($urandom_range(1) == 1);
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      void'($urandom(64176));
      cycle_count   = 0;
      saw_stall     = 1'b0;
      saw_recover   = 1'b0;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      repeat (8) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;
      // Idle state right after reset
      @(negedge axi_aclk);
      check_value("m_axis_tvalid", CMP_WIDTH'(m_axis_tvalid), CMP_WIDTH'(1'b0));
      check_value("s_axis_tready", CMP_WIDTH'(s_axis_tready), CMP_WIDTH'(1'b1));
      @(posedge axi_aclk);
      #1;
      for (int p = 0; p < NUM_PACKETS; p++) begin
         send_packet();
      end
      // Let the pipeline drain
      repeat (200) begin
         if (expected_q.size() == 0) begin
            break;
         end
         @(posedge axi_aclk);
      end
      repeat (4) @(posedge axi_aclk);
      if (expected_q.size() != 0) begin
         fail_run($sformatf("%0d beats were lost in the DUT", expected_q.size()));
      end else if (!saw_stall || !saw_recover) begin
         fail_run("s_axis_tready never dropped and recovered under back-pressure");
      end else if (mac_packets == 0 || cpu_packets == 0) begin
         fail_run("Packets from one side of the port map were never sent");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* rtl/nic_bypass_top.sv */
/*
 * CPU-bypass stage top level, lookup followed by output slice
 */
`timescale 1ns/1ns
`default_nettype none

module nic_bypass_top #(
   parameter int SRC_PORT_POS    = 16,
   parameter int DST_PORT_POS    = 24,
   parameter int FIFO_DEPTH_BITS = 2
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // Slave stream from the RX queues
   input  nic_bypass_pkg::axis_data_t s_axis_tdata,
   input  nic_bypass_pkg::axis_strb_t s_axis_tstrb,
   input  nic_bypass_pkg::axis_user_t s_axis_tuser,
   input  logic                      s_axis_tvalid,
   input  logic                      s_axis_tlast,
   output logic                      s_axis_tready,

   // Master stream to the data path
   output nic_bypass_pkg::axis_data_t m_axis_tdata,
   output nic_bypass_pkg::axis_strb_t m_axis_tstrb,
   output nic_bypass_pkg::axis_user_t m_axis_tuser,
   output logic                      m_axis_tvalid,
   output logic                      m_axis_tlast,
   input  logic                      m_axis_tready
);

   import nic_bypass_pkg::*;

   // Lookup to slice handshake
   axis_beat_t lookup_beat;
   logic       lookup_valid;
   logic       lookup_ready;

   output_port_lookup #(
      .SRC_PORT_POS    (SRC_PORT_POS),
      .DST_PORT_POS    (DST_PORT_POS),
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) output_port_lookup_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tready (s_axis_tready),
      .out_beat      (lookup_beat),
      .out_valid     (lookup_valid),
      .out_ready     (lookup_ready)
   );

   // Output slice cuts the ready path to downstream
   axis_register_slice axis_register_slice_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .in_beat       (lookup_beat),
      .in_valid      (lookup_valid),
      .in_ready      (lookup_ready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tready (m_axis_tready)
   );

endmodule

`default_nettype wire

/* rtl/axis_register_slice.sv */
/*
 * Two-entry output register slice
 * Main and skid registers, registered ready
 */
`timescale 1ns/1ns
`default_nettype none

module axis_register_slice (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // From the lookup
   input  nic_bypass_pkg::axis_beat_t in_beat,
   input  logic                      in_valid,
   output logic                      in_ready,

   // Downstream stream
   output nic_bypass_pkg::axis_data_t m_axis_tdata,
   output nic_bypass_pkg::axis_strb_t m_axis_tstrb,
   output nic_bypass_pkg::axis_user_t m_axis_tuser,
   output logic                      m_axis_tvalid,
   output logic                      m_axis_tlast,
   input  logic                      m_axis_tready
);

   import nic_bypass_pkg::*;

   axis_beat_t main_beat;
   axis_beat_t skid_beat;
   logic       main_valid;
   logic       skid_valid;
   logic       in_fire;
   logic       main_free;

   assign in_fire   = in_valid && in_ready;
   // Main register empty or draining this cycle
   assign main_free = !main_valid || m_axis_tready;

   //////////////////////////////
   // Control
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
         in_ready   <= 1'b1;
      end else if (main_free) begin
         // Skid drains first, else take the new beat
         main_valid <= skid_valid || in_fire;
         skid_valid <= 1'b0;
         in_ready   <= 1'b1;
      end else if (in_fire) begin
         // Stall with a beat in flight, park it
         skid_valid <= 1'b1;
         in_ready   <= 1'b0;
      end
   end

   //////////////////////////////
   // Payload
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (main_free) begin
         main_beat <= skid_valid ? skid_beat : in_beat;
      end
      if (in_fire && !main_free) begin
         skid_beat <= in_beat;
      end
   end

   assign m_axis_tvalid = main_valid;
   assign m_axis_tlast  = main_beat.last;
   assign m_axis_tuser  = main_beat.user;
   assign m_axis_tstrb  = main_beat.strb;
   assign m_axis_tdata  = main_beat.data;

   // Stalled beat holds until taken
   a_out_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(main_beat)));

endmodule

`default_nettype wire

/* rtl/output_port_lookup.sv */
/*
 * Output port lookup with its input FIFO
 * Header FSM, MAC to CPU and CPU to MAC destination rewrite
 */
`timescale 1ns/1ns
`default_nettype none

module output_port_lookup #(
   parameter int SRC_PORT_POS    = 16,
   parameter int DST_PORT_POS    = 24,
   parameter int FIFO_DEPTH_BITS = 2
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // Upstream stream
   input  nic_bypass_pkg::axis_data_t s_axis_tdata,
   input  nic_bypass_pkg::axis_strb_t s_axis_tstrb,
   input  nic_bypass_pkg::axis_user_t s_axis_tuser,
   input  logic                      s_axis_tvalid,
   input  logic                      s_axis_tlast,
   output logic                      s_axis_tready,

   // Toward the output slice
   output nic_bypass_pkg::axis_beat_t out_beat,
   output logic                      out_valid,
   input  logic                      out_ready
);

   import nic_bypass_pkg::*;

   lookup_state_t state;
   port_map_t     src_port;
   port_map_t     dst_port;
   logic          from_cpu;
   logic          in_fire;
   axis_beat_t    wr_beat;
   logic          fifo_empty;
   logic          fifo_nearly_full;
   logic          fifo_rd_en;

   //////////////////////////////
   // Port mapping
   //////////////////////////////

   assign src_port = s_axis_tuser[SRC_PORT_POS +: PORT_MAP_WIDTH];
   // Odd bits are CPU queues
   assign from_cpu = |(src_port & 8'hAA);
   // CPU queue goes down to its MAC, MAC goes up to its queue
   assign dst_port = from_cpu ? {1'b0, src_port[PORT_MAP_WIDTH-1:1]}
                              : {src_port[PORT_MAP_WIDTH-2:0], 1'b0};

   assign s_axis_tready = !fifo_nearly_full;
   assign in_fire       = s_axis_tvalid && s_axis_tready;

   // Rewrite ahead of the FIFO write, no extra cycle
   always_comb begin
      wr_beat.last = s_axis_tlast;
      wr_beat.user = s_axis_tuser;
      wr_beat.strb = s_axis_tstrb;
      wr_beat.data = s_axis_tdata;
      // Only the first beat carries the destination
      if (state == module_header) begin
         wr_beat.user[DST_PORT_POS +: PORT_MAP_WIDTH] = dst_port;
      end
   end

   //////////////////////////////
   // Header FSM
   //////////////////////////////

   // Moves on accepted beats only
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= module_header;
      end else if (in_fire) begin
         case (state)
            module_header: begin
               // Single-beat packet stays in header
               if (!s_axis_tlast) begin
                  state <= in_packet;
               end
            end
            in_packet: begin
               if (s_axis_tlast) begin
                  state <= module_header;
               end
            end
            default: state <= module_header;
         endcase
      end
   end

   //////////////////////////////
   // Input FIFO
   //////////////////////////////

   stream_fifo #(
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) input_fifo_inst (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (wr_beat),
      .wr_en       (in_fire),
      .rd_en       (fifo_rd_en),
      .dout        (out_beat),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   // Head of the FIFO is the offered beat
   assign out_valid  = !fifo_empty;
   assign fifo_rd_en = out_valid && out_ready;

   // Every packet starts from exactly one port
   a_src_onehot: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (in_fire && state == module_header) |-> $onehot(src_port));

endmodule

`default_nettype wire

/* rtl/stream_fifo.sv */
/*
 * First-word-fall-through FIFO of stream beats
 * Circular buffer with count, head on dout, nearly-full flag
 */
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
   parameter int FIFO_DEPTH_BITS = 2
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,
   input  nic_bypass_pkg::axis_beat_t din,
   input  logic                      wr_en,
   input  logic                      rd_en,
   output nic_bypass_pkg::axis_beat_t dout,
   output logic                      empty,
   output logic                      nearly_full
);

   import nic_bypass_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_BITS;
   // Fill levels at the count width
   localparam logic [FIFO_DEPTH_BITS:0] FULL_LEVEL = (FIFO_DEPTH_BITS+1)'(DEPTH);
   localparam logic [FIFO_DEPTH_BITS:0] NF_LEVEL   = (FIFO_DEPTH_BITS+1)'(DEPTH - 1);

   axis_beat_t                 mem [DEPTH];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS:0]   count;

   //////////////////////////////
   // Storage
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // Head entry falls through
   assign dout = mem[rd_ptr];

   //////////////////////////////
   // Pointers and count
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the power-of-two depth
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty       = (count == '0);
   // One entry or fewer free
   assign nearly_full = (count >= NF_LEVEL);

   // Producer and consumer respect the flags
   a_no_overflow: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(wr_en && count == FULL_LEVEL));
   a_no_underflow: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(rd_en && empty));

endmodule

`default_nettype wire

/* rtl/nic_bypass_pkg.sv */
/*
 * Stream widths, port byte and beat typedefs for the bypass data path
 * Beat struct and lookup state encoding
 */
`default_nettype none

package nic_bypass_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // Beat payload and sideband sizes
   localparam int AXIS_DATA_WIDTH = 256;
   localparam int AXIS_STRB_WIDTH = AXIS_DATA_WIDTH / 8;
   localparam int AXIS_USER_WIDTH = 128;
   // One bit per MAC port and per CPU queue
   localparam int PORT_MAP_WIDTH  = 8;

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef logic [AXIS_DATA_WIDTH-1:0] axis_data_t;
   typedef logic [AXIS_STRB_WIDTH-1:0] axis_strb_t;
   typedef logic [AXIS_USER_WIDTH-1:0] axis_user_t;
   // Even bits are MAC ports, odd bits their CPU queues
   typedef logic [PORT_MAP_WIDTH-1:0]  port_map_t;

   // One stream beat, last on top, data at the bottom
   typedef struct packed {
      logic       last;
      axis_user_t user;
      axis_strb_t strb;
      axis_data_t data;
   } axis_beat_t;

   // Header tracking in the lookup
   typedef enum logic {
      module_header,
      in_packet
   } lookup_state_t;

endpackage

`default_nettype wire
